/* Makefile */
SRCS = $(filter-out +incdir+%,$(shell cat src.f)) logic/playback_cfg.svh

.PHONY: run clean

run: obj_dir/Vtb_playback
	./obj_dir/Vtb_playback 2>&1 | tee sim.log
	@! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log

obj_dir/Vtb_playback: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_playback \
		-f src.f -Mdir obj_dir -o Vtb_playback

clean:
	rm -rf obj_dir sim.log

/* logic/buffer_pkg.sv */
`include "playback_cfg.svh"

package buffer_pkg;

  // Next read index, wrapping naturally at the address width
  function automatic logic [`PB_ADDR_W-1:0] next_index(
    input logic [`PB_ADDR_W-1:0] idx
  );
    return idx + 1'b1;
  endfunction

  // True once the index has reached the configured end of the buffer
  function automatic logic at_last(
    input logic [`PB_ADDR_W-1:0] idx,
    input logic [`PB_ADDR_W-1:0] last_index
  );
    return idx >= last_index;
  endfunction

endpackage

/* logic/iq_gain.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module iq_gain (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic [`PB_GAIN_W-1:0]    gain,
  input  logic                     s_valid,
  output logic                     s_ready,
  input  sample_pkg::sample_word_t s_data,
  input  logic                     s_last,
  output logic                     m_valid,
  input  logic                     m_ready,
  output sample_pkg::sample_word_t m_data,
  output logic                     m_last
);

  import sample_pkg::*;

  sample_word_t scaled;
  logic         valid_q;
  logic         load;

  // Take a new beat when the output slot is empty or drains this cycle
  assign s_ready = ~valid_q | m_ready;
  assign load    = s_valid & s_ready;

  // ************************************************************
  // Per-half scaling
  // ************************************************************

  always_comb
  begin
    scaled.iq.i = scale_sat(s_data.iq.i, gain);
    scaled.iq.q = scale_sat(s_data.iq.q, gain);
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      valid_q <= 1'b0;
    end
    else if (s_ready)
    begin
      valid_q <= s_valid;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (load)
    begin
      m_data <= scaled;
      m_last <= s_last;  // Travels with its beat
    end
  end

  assign m_valid = valid_q;

  // The downstream side sees a held beat until it takes it
  a_out_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last)
  );

endmodule

/* logic/playback_cfg.svh */
`ifndef PLAYBACK_CFG_SVH
`define PLAYBACK_CFG_SVH

// ************************************************************
// Buffer geometry
// ************************************************************

`define PB_ADDR_W      8    // 256 words of sample memory
`define PB_SAMPLE_W    32   // One complex sample, I in the upper half
`define PB_HALF_W      (`PB_SAMPLE_W/2)

// ************************************************************
// Gain stage
// ************************************************************

`define PB_GAIN_W      8
`define PB_GAIN_SHIFT  6    // A gain of 64 passes the sample unchanged

`endif

/* logic/playback_top.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module playback_top (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Host write port
  input  logic                     wr_clear,
  input  logic                     wr_en,
  input  sample_pkg::sample_word_t wr_data,
  output logic [`PB_ADDR_W:0]      fill_count,
  // Reader control and status
  input  logic [`PB_ADDR_W-1:0]    last_index,
  input  logic                     loop,
  input  logic                     start,
  output logic [`PB_ADDR_W-1:0]    position,
  output logic                     done,
  input  logic                     done_ack,
  // Output stream
  input  logic [`PB_GAIN_W-1:0]    gain,
  output logic                     m_valid,
  input  logic                     m_ready,
  output sample_pkg::sample_word_t m_data,
  output logic                     m_last
);

  import sample_pkg::*;

  logic                  ram_we;
  logic [`PB_ADDR_W-1:0] ram_waddr;
  sample_word_t          ram_wdata;
  logic [`PB_ADDR_W-1:0] rd_addr;
  sample_word_t          rd_data;
  logic                  s_valid;
  logic                  s_ready;
  sample_word_t          s_data;
  logic                  s_last;

  ram_loader u_ram_loader (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_clear   (wr_clear),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .ram_we     (ram_we),
    .ram_waddr  (ram_waddr),
    .ram_wdata  (ram_wdata),
    .fill_count (fill_count)
  );

  sample_ram u_sample_ram (
    .aclk  (aclk),
    .we    (ram_we),
    .waddr (ram_waddr),
    .wdata (ram_wdata),
    .raddr (rd_addr),
    .rdata (rd_data)
  );

  stream_reader u_stream_reader (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .last_index (last_index),
    .loop       (loop),
    .start      (start),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .s_last     (s_last),
    .done       (done),
    .done_ack   (done_ack),
    .position   (position)
  );

  iq_gain u_iq_gain (
    .aclk    (aclk),
    .aresetn (aresetn),
    .gain    (gain),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_last  (s_last),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

endmodule

/* logic/ram_loader.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module ram_loader (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     wr_clear,
  input  logic                     wr_en,
  input  sample_pkg::sample_word_t wr_data,
  output logic                     ram_we,
  output logic [`PB_ADDR_W-1:0]    ram_waddr,
  output sample_pkg::sample_word_t ram_wdata,
  output logic [`PB_ADDR_W:0]      fill_count
);

  logic [`PB_ADDR_W-1:0] waddr_q;
  logic [`PB_ADDR_W:0]   count_q;
  logic                  full;

  // The count stops at the depth, which is the only value with the top bit set
  assign full = count_q[`PB_ADDR_W];

  // Clear wins over a write in the same cycle
  assign ram_we    = wr_en & ~wr_clear & ~full;
  assign ram_waddr = waddr_q;
  assign ram_wdata = wr_data;

  always_ff @(posedge aclk)
  begin
    if (!aresetn || wr_clear)
    begin
      waddr_q <= '0;
      count_q <= '0;
    end
    else if (ram_we)
    begin
      waddr_q <= waddr_q + 1'b1;
      count_q <= count_q + 1'b1;
    end
  end

  assign fill_count = count_q;

  // The host must not push more words than the buffer holds
  a_no_write_when_full : assert property (
    @(posedge aclk) disable iff (!aresetn)
    wr_en && !wr_clear |-> !full
  );

endmodule

/* logic/sample_pkg.sv */
`include "playback_cfg.svh"

package sample_pkg;

  // One memory word, seen either as a plain word or as its two halves
  typedef union packed {
    logic [`PB_SAMPLE_W-1:0] raw;
    struct packed {
      logic signed [`PB_HALF_W-1:0] i;
      logic signed [`PB_HALF_W-1:0] q;
    } iq;
  } sample_word_t;

  // Signed half times unsigned gain, fraction bits dropped, clamped to the half range
  function automatic logic signed [`PB_HALF_W-1:0] scale_sat(
    input logic signed [`PB_HALF_W-1:0] half,
    input logic [`PB_GAIN_W-1:0] gain
  );
    logic signed [`PB_HALF_W+`PB_GAIN_W:0] prod;
    logic signed [`PB_HALF_W+`PB_GAIN_W:0] shifted;
    prod = half * $signed({1'b0, gain});
    shifted = prod >>> `PB_GAIN_SHIFT;
    // All bits above the half must repeat the sign, otherwise the result overflowed
    if (shifted[`PB_HALF_W+`PB_GAIN_W:`PB_HALF_W-1] !=
        {(`PB_GAIN_W+2){shifted[`PB_HALF_W+`PB_GAIN_W]}})
    begin
      return shifted[`PB_HALF_W+`PB_GAIN_W] ? {1'b1, {(`PB_HALF_W-1){1'b0}}}
                                            : {1'b0, {(`PB_HALF_W-1){1'b1}}};
    end
    return shifted[`PB_HALF_W-1:0];
  endfunction

endpackage

/* logic/sample_ram.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module sample_ram (
  input  logic                     aclk,
  input  logic                     we,
  input  logic [`PB_ADDR_W-1:0]    waddr,
  input  sample_pkg::sample_word_t wdata,
  input  logic [`PB_ADDR_W-1:0]    raddr,
  output sample_pkg::sample_word_t rdata
);

  logic [`PB_SAMPLE_W-1:0] mem [0:(1 << `PB_ADDR_W)-1];

  always_ff @(posedge aclk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata.raw;
    end
  end

  // Registered read. A read of the address being written returns the old word
  always_ff @(posedge aclk)
  begin
    rdata.raw <= mem[raddr];
  end

endmodule

/* logic/stream_reader.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module stream_reader (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic [`PB_ADDR_W-1:0]    last_index,
  input  logic                     loop,
  input  logic                     start,
  output logic [`PB_ADDR_W-1:0]    rd_addr,
  input  sample_pkg::sample_word_t rd_data,
  output logic                     s_valid,
  input  logic                     s_ready,
  output sample_pkg::sample_word_t s_data,
  output logic                     s_last,
  output logic                     done,
  input  logic                     done_ack,
  output logic [`PB_ADDR_W-1:0]    position
);

  import buffer_pkg::*;

  logic [`PB_ADDR_W-1:0] idx_q, idx_next;
  logic                  enbl_q, enbl_next;
  logic                  armed_q, armed_next;
  logic                  done_q, done_next;
  logic                  accept;
  logic                  last_beat;

  assign last_beat = at_last(idx_q, last_index);
  assign accept    = enbl_q & s_ready;

  // ************************************************************
  // Index, enable and completion state
  // ************************************************************

  always_comb
  begin
    idx_next   = idx_q;
    enbl_next  = enbl_q;
    armed_next = armed_q;
    done_next  = done_q;

    if (!enbl_q && armed_q && (idx_q <= last_index))
    begin
      enbl_next  = 1'b1;  // One cycle of arming latency
      armed_next = 1'b0;
    end

    if (accept)
    begin
      if (!last_beat)
      begin
        idx_next = next_index(idx_q);
      end
      else if (loop)
      begin
        idx_next = '0;
      end
      else
      begin
        enbl_next = 1'b0;
        done_next = 1'b1;
      end
    end

    if (done_q && done_ack)
    begin
      done_next = 1'b0;
    end

    // Re-arm from index 0, overriding anything in flight
    if (start)
    begin
      idx_next   = '0;
      enbl_next  = 1'b0;
      armed_next = 1'b1;
      done_next  = 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      idx_q   <= '0;
      enbl_q  <= 1'b0;
      armed_q <= 1'b1;  // Reset arms the reader like a start pulse
      done_q  <= 1'b0;
    end
    else
    begin
      idx_q   <= idx_next;
      enbl_q  <= enbl_next;
      armed_q <= armed_next;
      done_q  <= done_next;
    end
  end

  // Ask the RAM for the next index so its registered output lines up with idx_q
  assign rd_addr = idx_next;

  assign s_valid  = enbl_q;
  assign s_data   = rd_data;
  assign s_last   = enbl_q & last_beat;
  assign done     = done_q;
  assign position = idx_q;

  // A stalled beat keeps its data across the reader and the RAM read port
  a_stall_hold : assert property (
    @(posedge aclk) disable iff (!aresetn)
    s_valid && !s_ready && !start |=> s_valid && $stable(s_data)
  );

  // Completion and a live stream never overlap
  a_done_idle : assert property (
    @(posedge aclk) disable iff (!aresetn)
    done |-> !s_valid
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 100.0
) (
  output logic aclk
);

  initial
  begin
    aclk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2.0) aclk = ~aclk;
    end
  end

endmodule

/* sim/tb_playback.sv */
`timescale 1ns/1ps

`include "playback_cfg.svh"

module tb_playback;

  import sample_pkg::*;
  import buffer_pkg::*;

  // Rough cycle budget of each test
  localparam int LEN_ONESHOT     = 60;
  localparam int LEN_HANDSHAKE   = 50;
  localparam int LEN_BACKPRES    = 70;
  localparam int LEN_LOOP        = 70;
  localparam int LEN_GAIN        = 200;
  localparam int WATCHDOG_CYCLES =
    4 * (LEN_ONESHOT + LEN_HANDSHAKE + LEN_BACKPRES + LEN_LOOP + LEN_GAIN);

  // I in the upper half, Q in the lower, both ends of the range
  localparam logic [31:0] EXTREMES [8] = '{
    32'h8000_7fff, 32'h7fff_8000, 32'h0001_ffff, 32'h0000_0000,
    32'h8000_8000, 32'h7fff_7fff, 32'hc000_4000, 32'h0100_ff00
  };

  logic                    aclk, aresetn, wr_clear, wr_en;
  sample_word_t            wr_data, m_data;
  logic [`PB_ADDR_W:0]     fill_count, exp_fill;
  logic [`PB_ADDR_W-1:0]   last_index, position;
  logic                    loop, start, done, done_ack;
  logic [`PB_GAIN_W-1:0]   gain;
  logic                    m_valid, m_ready, m_last;

  logic [31:0]             lfsr_state;
  logic [`PB_SAMPLE_W-1:0] ram_model [0:(1 << `PB_ADDR_W)-1];
  logic [`PB_SAMPLE_W:0]   exp_q [$];  // {last, word} per expected beat
  logic [`PB_SAMPLE_W-1:0] exp_head;
  logic                    exp_last, monitor_on, fill_check;
  int                      exp_count, fail_count, fails_at_start;
  int                      tests_passed, tests_failed;
  string                   test_name;

  tb_clock #(.PERIOD_NS(100.0)) u_tb_clock (.aclk(aclk));

  playback_top u_playback_top (.*);

  // ************************************************************
  // Stimulus helpers and reference model
  // ************************************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Product, arithmetic shift by the fraction bits, then clamp to 16 bits signed
  function automatic logic signed [`PB_HALF_W-1:0] expect_half(
    input logic signed [`PB_HALF_W-1:0] half,
    input logic [`PB_GAIN_W-1:0] g
  );
    int p;
    p = int'(half) * int'(g);
    p = p >>> `PB_GAIN_SHIFT;
    if (p > 32767)
    begin
      p = 32767;
    end
    else if (p < -32768)
    begin
      p = -32768;
    end
    return p[`PB_HALF_W-1:0];
  endfunction

  function automatic logic [`PB_SAMPLE_W-1:0] expect_word(
    input logic [`PB_SAMPLE_W-1:0] w,
    input logic [`PB_GAIN_W-1:0] g
  );
    sample_word_t x, y;
    x.raw = w;
    y.iq.i = expect_half(x.iq.i, g);
    y.iq.q = expect_half(x.iq.q, g);
    return y.raw;
  endfunction

  function automatic void refresh_head();
    exp_count = exp_q.size();
    if (exp_count != 0)
    begin
      exp_head = exp_q[0][`PB_SAMPLE_W-1:0];
      exp_last = exp_q[0][`PB_SAMPLE_W];
    end
  endfunction

  // Beats taken at this edge leave the model before inputs move
  task automatic tick();
    @(posedge aclk);
    if (monitor_on && m_valid && m_ready && exp_q.size() != 0)
    begin
      void'(exp_q.pop_front());
    end
    refresh_head();
    #1;
  endtask

  task automatic load_buffer(input int n, input bit use_extremes);
    logic [`PB_ADDR_W-1:0] a;
    a = '0;
    wr_clear = 1'b1;
    tick();
    wr_clear = 1'b0;
    for (int k = 0; k < n; k++)
    begin
      if (use_extremes && k < 8)
      begin
        wr_data.raw = EXTREMES[k[2:0]];
      end
      else
      begin
        wr_data.raw = rand_bits(32);
      end
      ram_model[a] = wr_data.raw;
      a = next_index(a);
      wr_en = 1'b1;
      tick();
    end
    wr_en = 1'b0;
    exp_fill = n[`PB_ADDR_W:0];
    fill_check = 1'b1;
    tick();
    fill_check = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int cycles;
    cycles = 0;
    while (!done && cycles < limit)
    begin
      tick();
      cycles++;
    end
    if (!done)
    begin
      $display("%s: timed out waiting for done", test_name);
      fail_count++;
    end
  endtask

  task automatic wait_queue_empty(input int limit, input bit random_ready);
    int cycles;
    cycles = 0;
    while (exp_count != 0 && cycles < limit)
    begin
      m_ready = random_ready ? (rand_bits(1) != 0) : 1'b1;
      tick();
      cycles++;
    end
    if (exp_count != 0)
    begin
      $display("%s: timed out with %0d beats still expected", test_name, exp_count);
      fail_count++;
    end
  endtask

  // Runs the reader out to completion with the checks off
  task automatic drain();
    monitor_on = 1'b0;
    loop = 1'b0;
    m_ready = 1'b1;
    wait_done(4 * (1 << `PB_ADDR_W));
    done_ack = 1'b1;
    tick();
    done_ack = 1'b0;
    repeat (3) tick();
    exp_q.delete();
    refresh_head();
    monitor_on = 1'b1;
  endtask

  task automatic play(input int last, input int rounds, input bit loop_mode,
                      input logic [`PB_GAIN_W-1:0] g, input bit random_ready,
                      input int hold);
    logic [`PB_ADDR_W-1:0] idx;
    for (int r = 0; r < rounds; r++)
    begin
      idx = '0;
      for (int k = 0; k <= last; k++)
      begin
        exp_q.push_back({k == last, expect_word(ram_model[idx], g)});
        idx = next_index(idx);
      end
    end
    refresh_head();
    last_index = last[`PB_ADDR_W-1:0];
    loop = loop_mode;
    gain = g;
    start = 1'b1;
    tick();
    start = 1'b0;
    wait_queue_empty(8 * rounds * (last + 1) + 20, random_ready);
    if (loop_mode)
    begin
      drain();
    end
    else
    begin
      m_ready = 1'b1;
      wait_done(20);
      repeat (hold) tick();  // done must hold and no beat may appear
      done_ack = 1'b1;
      tick();
      done_ack = 1'b0;
      repeat (hold + 2) tick();
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    fails_at_start = fail_count;
  endtask

  task automatic end_test();
    if (fail_count == fails_at_start)
    begin
      $display("%s passed", test_name);
      tests_passed++;
    end
    else
    begin
      $display("%s failed with %0d errors", test_name, fail_count - fails_at_start);
      tests_failed++;
    end
  endtask

  // ************************************************************
  // Checks
  // ************************************************************

  a_beat_expected : assert property (
    @(posedge aclk) disable iff (!aresetn)
    monitor_on && m_valid && m_ready |-> exp_count != 0
  )
  else
  begin
    $display("%s: output beat arrived when none was expected", test_name);
    fail_count++;
  end

  a_beat_match : assert property (
    @(posedge aclk) disable iff (!aresetn)
    monitor_on && m_valid && m_ready && exp_count != 0 |->
      m_data.raw == exp_head && m_last == exp_last
  )
  else
  begin
    $display("error %s: expected %h actual %h", test_name,
             $sampled({exp_last, exp_head}), $sampled({m_last, m_data.raw}));
    fail_count++;
  end

  a_fill_count : assert property (
    @(posedge aclk) disable iff (!aresetn)
    fill_check |-> fill_count == exp_fill
  )
  else
  begin
    $display("error %s: expected %0d actual %0d", test_name,
             $sampled(exp_fill), $sampled(fill_count));
    fail_count++;
  end

  // Held until acknowledged, then gone one edge later
  a_done_handshake : assert property (
    @(posedge aclk) disable iff (!aresetn)
    done && !start |=> done != $past(done_ack)
  )
  else
  begin
    $display("%s: done did not follow done_ack", test_name);
    fail_count++;
  end

  a_loop_no_done : assert property (
    @(posedge aclk) disable iff (!aresetn)
    loop |-> !done
  )
  else
  begin
    $display("%s: done went high in loop mode", test_name);
    fail_count++;
  end

  // A start pulse sends the reader back to index 0
  a_position_restart : assert property (
    @(posedge aclk) disable iff (!aresetn)
    start |=> position == '0
  )
  else
  begin
    $display("error %s: expected %0d actual %0d", test_name,
             0, $sampled(position));
    fail_count++;
  end

  // A finished one-shot run parks the reader on the last index
  a_position_at_done : assert property (
    @(posedge aclk) disable iff (!aresetn)
    done && !start |-> position == last_index
  )
  else
  begin
    $display("error %s: expected %0d actual %0d", test_name,
             $sampled(last_index), $sampled(position));
    fail_count++;
  end

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial
  begin
    logic [31:0] r;
    lfsr_state   = 32'h7363;
    aresetn      = 1'b0;
    wr_clear     = 1'b0;
    wr_en        = 1'b0;
    wr_data      = '0;
    last_index   = '0;
    loop         = 1'b0;
    start        = 1'b0;
    done_ack     = 1'b0;
    gain         = 8'd64;
    m_ready      = 1'b0;
    monitor_on   = 1'b0;
    fill_check   = 1'b0;
    exp_fill     = '0;
    exp_head     = '0;
    exp_last     = 1'b0;
    fail_count   = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "reset";
    refresh_head();
    repeat (5) tick();
    aresetn = 1'b1;
    drain();  // Reset arms the reader on whatever the RAM holds

    begin_test("oneshot_playback");
    load_buffer(20, 1'b0);
    play(19, 1, 1'b0, 8'd64, 1'b0, 2);
    end_test();

    begin_test("done_handshake");
    play(7, 1, 1'b0, 8'd64, 1'b0, 12);
    end_test();

    begin_test("back_pressure");
    play(19, 1, 1'b0, 8'd64, 1'b1, 2);
    end_test();

    begin_test("loop_mode");
    play(9, 4, 1'b1, 8'd64, 1'b0, 0);
    end_test();

    begin_test("gain_saturation");
    load_buffer(24, 1'b1);
    play(23, 1, 1'b0, 8'd0, 1'b0, 2);
    play(23, 1, 1'b0, 8'd64, 1'b0, 2);
    play(23, 1, 1'b0, 8'd255, 1'b0, 2);
    r = rand_bits(8);
    play(23, 1, 1'b0, r[7:0], 1'b1, 2);
    r = rand_bits(8);
    play(23, 1, 1'b0, r[7:0], 1'b0, 2);
    end_test();

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && fail_count == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/sample_pkg.sv
logic/buffer_pkg.sv
logic/sample_ram.sv
logic/ram_loader.sv
logic/stream_reader.sv
logic/iq_gain.sv
logic/playback_top.sv
sim/tb_clock.sv
sim/tb_playback.sv
